/* project.f */
+incdir+test
hdl/encoder_pkg.sv
hdl/axil_register_bank.sv
hdl/quadrature_decoder.sv
hdl/index_speed_meter.sv
hdl/encoder_interface.sv
test/tb_encoder_interface.sv

/* Bender.yml */
package:
  name: encoder_interface

sources:
  - hdl/encoder_pkg.sv
  - hdl/axil_register_bank.sv
  - hdl/quadrature_decoder.sv
  - hdl/index_speed_meter.sv
  - hdl/encoder_interface.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_encoder_interface.sv

/* test/tb_encoder_tasks.svh */
/*
 * Encoder front end testbench tasks
 * AXI4-Lite drivers, encoder line stimulus and the directed tests
 */

// Ready and valid flags of the slave are registered, so they are stable at the falling edge
task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    logic aw_taken;
    logic w_taken;
    @(negedge clock);
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    while (axil_req.awvalid || axil_req.wvalid) begin
        aw_taken = axil_req.awvalid && axil_rsp.awready;
        w_taken  = axil_req.wvalid && axil_rsp.wready;
        @(negedge clock);
        if (aw_taken) axil_req.awvalid = 1'b0;
        if (w_taken) axil_req.wvalid = 1'b0;
    end
    while (!axil_rsp.bvalid) @(negedge clock);
    resp = axil_rsp.bresp;
    @(negedge clock);
    axil_req.bready = 1'b0;
endtask

task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    logic ar_taken;
    @(negedge clock);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    while (axil_req.arvalid) begin
        ar_taken = axil_rsp.arready;
        @(negedge clock);
        if (ar_taken) axil_req.arvalid = 1'b0;
    end
    while (!axil_rsp.rvalid) @(negedge clock);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(negedge clock);
    axil_req.rready = 1'b0;
endtask

// Each step holds for two cycles and A leads B when moving forward
task automatic step_encoder(input bit forward, input int steps);
    for (int i = 0; i < steps; i++) begin
        quad_pos = forward ? (quad_pos + 1) % 4 : (quad_pos + 3) % 4;
        @(negedge clock);
        a = (quad_pos == 1) || (quad_pos == 2);
        b = (quad_pos >= 2);
        @(negedge clock);
    end
    // Two synchronizer stages and the edge detect before the count settles
    repeat (4) @(negedge clock);
endtask

task automatic pulse_z();
    @(negedge clock);
    z = 1'b1;
    @(negedge clock);
    z = 1'b0;
    repeat (4) @(negedge clock);
endtask

// A zero counts-per-revolution holds the count at zero for a cycle
task automatic clear_count();
    logic [1:0] resp;
    axil_write(8'h08, 32'd0, resp);
    axil_write(8'h08, max_count, resp);
endtask

task automatic strobe_sample(input bit speed);
    @(negedge clock);
    if (speed) sample_speed = 1'b1;
    else sample_angle = 1'b1;
    @(negedge clock);
    sample_speed = 1'b0;
    sample_angle = 1'b0;
endtask

// Samples one stream, waits for its beat and accepts it in a single cycle
task automatic collect_beat(input bit speed, output encoder_pkg::axis_beat_t beat);
    strobe_sample(speed);
    while (!(speed ? speed_tvalid : angle_tvalid)) @(negedge clock);
    beat = speed ? speed_beat : angle_beat;
    if (speed) speed_tready = 1'b1;
    else angle_tready = 1'b1;
    @(negedge clock);
    speed_tready = 1'b0;
    angle_tready = 1'b0;
    if ((speed ? speed_tvalid : angle_tvalid) !== 1'b0) report_value("tvalid after accept", 1, 0);
endtask

task automatic check_register_access();
    int          errors_before;
    logic [1:0]  resp;
    logic [31:0] data;
    errors_before = error_count;
    if ({axil_rsp.awready, axil_rsp.wready, axil_rsp.arready} !== 3'b111)
        report_value("ready flags after reset",
                     {axil_rsp.awready, axil_rsp.wready, axil_rsp.arready}, 3'b111);
    if ({angle_tvalid, speed_tvalid, axil_rsp.bvalid, axil_rsp.rvalid} !== 4'b0000)
        report_value("valid flags after reset", 1, 0);
    axil_write(8'h00, angle_dest, resp);
    axil_write(8'h04, speed_dest, resp);
    axil_write(8'h08, max_count, resp);
    axil_write(8'h14, 32'h0000_0100, resp);
    if (resp !== encoder_pkg::resp_okay) report_value("control write bresp", resp, 0);
    axil_read(8'h00, data, resp);
    if (data !== angle_dest) report_value("register 0", data, angle_dest);
    axil_read(8'h04, data, resp);
    if (data !== speed_dest) report_value("register 1", data, speed_dest);
    axil_read(8'h08, data, resp);
    if (data !== max_count) report_value("register 2", data, max_count);
    axil_read(8'h14, data, resp);
    if (data !== 32'h0000_0100) report_value("register 5", data, 32'h0000_0100);
    // Angle register is read only so the write is accepted and dropped
    // No angle has been sampled since reset, so it still reads zero
    axil_write(8'h0c, 32'hdead_beef, resp);
    if (resp !== encoder_pkg::resp_okay) report_value("register 3 bresp", resp, 0);
    axil_read(8'h0c, data, resp);
    if (data !== 32'd0) report_value("register 3 after write", data, 0);
    axil_write(8'h18, 32'h1234_5678, resp);
    if (resp !== encoder_pkg::resp_slverr) report_value("unmapped bresp", resp, 2'b10);
    axil_read(8'h18, data, resp);
    if (data !== 32'd0) report_value("unmapped rdata", data, 0);
    if (resp !== encoder_pkg::resp_slverr) report_value("unmapped rresp", resp, 2'b10);
    finish_test("register access", errors_before);
endtask

task automatic measure_speed();
    int                      errors_before;
    logic [1:0]              resp;
    logic [31:0]             data;
    encoder_pkg::axis_beat_t beat;
    errors_before = error_count;
    pulse_z();
    collect_beat(1'b1, beat);
    if (beat.tdata !== 32'd0) report_value("speed after one pulse", beat.tdata, 0);
    // Two further pulses exactly index_spacing cycles apart
    @(negedge clock);
    z = 1'b1;
    @(negedge clock);
    z = 1'b0;
    repeat (index_spacing - 1) @(negedge clock);
    z = 1'b1;
    @(negedge clock);
    z = 1'b0;
    repeat (4) @(negedge clock);
    collect_beat(1'b1, beat);
    if (beat.tdata !== index_spacing) report_value("speed beat", beat.tdata, index_spacing);
    if (beat.tdest !== speed_dest[7:0]) report_value("speed tdest", beat.tdest, speed_dest);
    axil_read(8'h10, data, resp);
    if (data !== index_spacing) report_value("register 4", data, index_spacing);
    finish_test("index speed", errors_before);
endtask

task automatic count_forward();
    int                      errors_before;
    int                      steps;
    logic [1:0]              resp;
    logic [31:0]             data;
    logic [31:0]             expected;
    encoder_pkg::axis_beat_t beat;
    errors_before = error_count;
    steps = 16 + random_bits(7);
    expected = steps % max_count;
    clear_count();
    step_encoder(1'b1, steps);
    collect_beat(1'b0, beat);
    if (beat.tdata !== expected) report_value("forward angle beat", beat.tdata, expected);
    if (beat.tdest !== angle_dest[7:0]) report_value("angle tdest", beat.tdest, angle_dest);
    axil_read(8'h0c, data, resp);
    if (data !== expected) report_value("register 3", data, expected);
    finish_test("forward counting", errors_before);
endtask

task automatic wrap_reverse();
    int                      errors_before;
    int                      steps;
    logic [31:0]             expected;
    encoder_pkg::axis_beat_t beat;
    errors_before = error_count;
    steps = 1 + random_bits(7);
    expected = (max_count - steps % max_count) % max_count;
    clear_count();
    step_encoder(1'b0, steps);
    collect_beat(1'b0, beat);
    if (beat.tdata !== expected) report_value("reverse angle beat", beat.tdata, expected);
    finish_test("reverse wrap", errors_before);
endtask

// Same step and Z sequence run once with tracking on and once with it off
task automatic track_index();
    int                      errors_before;
    int                      lead_steps;
    int                      trail_steps;
    logic [1:0]              resp;
    encoder_pkg::axis_beat_t beat;
    errors_before = error_count;
    lead_steps  = 3 + random_bits(5);
    trail_steps = random_bits(4);
    for (int tracking = 1; tracking >= 0; tracking--) begin
        axil_write(8'h14, tracking, resp);
        clear_count();
        step_encoder(1'b1, lead_steps);
        pulse_z();
        step_encoder(1'b1, trail_steps);
        collect_beat(1'b0, beat);
        if (tracking == 1 && beat.tdata !== trail_steps % max_count)
            report_value("angle with tracking", beat.tdata, trail_steps % max_count);
        if (tracking == 0 && beat.tdata !== (lead_steps + trail_steps) % max_count)
            report_value("angle without tracking", beat.tdata,
                         (lead_steps + trail_steps) % max_count);
    end
    finish_test("index tracking", errors_before);
endtask

task automatic hold_under_backpressure();
    int                      errors_before;
    int                      steps;
    logic [1:0]              resp;
    logic [31:0]             data;
    logic [31:0]             expected;
    encoder_pkg::axis_beat_t first;
    errors_before = error_count;
    steps = 5 + random_bits(5);
    expected = steps % max_count;
    clear_count();
    step_encoder(1'b1, steps);
    strobe_sample(1'b0);
    while (!angle_tvalid) @(negedge clock);
    first = angle_beat;
    if (first.tdata !== expected) report_value("held beat", first.tdata, expected);
    // The beat must not move while the sink stalls
    repeat (6) begin
        @(negedge clock);
        if (angle_tvalid !== 1'b1) report_value("stalled tvalid", angle_tvalid, 1);
        if (angle_beat !== first) report_value("stalled beat", angle_beat.tdata, first.tdata);
    end
    // A strobe while the beat is pending is dropped
    step_encoder(1'b1, 3);
    strobe_sample(1'b0);
    @(negedge clock);
    if (angle_beat !== first) report_value("beat after dropped strobe", angle_beat.tdata,
                                           first.tdata);
    axil_read(8'h0c, data, resp);
    if (data !== expected) report_value("register 3 after dropped strobe", data, expected);
    angle_tready = 1'b1;
    @(negedge clock);
    angle_tready = 1'b0;
    if (angle_tvalid !== 1'b0) report_value("tvalid after one accept", angle_tvalid, 0);
    finish_test("back-pressure", errors_before);
endtask

/* test/tb_encoder_interface.sv */
/*
 * Testbench for the quadrature encoder front end
 * Drives the encoder lines, the sample strobes and the AXI4-Lite bus of the DUT,
 * and checks the angle and speed streams against the counting rules
 */
`timescale 1ns/1ps

module tb_encoder_interface;

    // The whole sequence needs well under 2000 cycles and the limit leaves a wide margin
    localparam int cycle_limit = 20000;

    // Register contents used throughout the run
    localparam logic [31:0] angle_dest    = 32'h0000_003a;
    localparam logic [31:0] speed_dest    = 32'h0000_005c;
    localparam int          max_count     = 48;
    localparam int          index_spacing = 137;

    logic                    clock;
    logic                    rst_n;
    logic                    a;
    logic                    b;
    logic                    z;
    logic                    sample_angle;
    logic                    sample_speed;
    logic                    angle_tready;
    logic                    speed_tready;
    logic                    angle_tvalid;
    logic                    speed_tvalid;
    encoder_pkg::axil_req_t  axil_req;
    encoder_pkg::axil_rsp_t  axil_rsp;
    encoder_pkg::axis_beat_t angle_beat;
    encoder_pkg::axis_beat_t speed_beat;

    // Encoder phase 0..3 along the forward Gray sequence
    int          quad_pos;
    logic [15:0] lfsr_state;
    int          cycle_count;
    int          error_count;
    int          pass_count;
    int          fail_count;

    always #5 clock = ~clock;

    encoder_interface #(
        .COUNTER_WIDTH (24)
    ) i_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .a            (a),
        .b            (b),
        .z            (z),
        .sample_angle (sample_angle),
        .sample_speed (sample_speed),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .angle_beat   (angle_beat),
        .angle_tvalid (angle_tvalid),
        .angle_tready (angle_tready),
        .speed_beat   (speed_beat),
        .speed_tvalid (speed_tvalid),
        .speed_tready (speed_tready)
    );

    // Watchdog that reports where the write channel was stuck if the run stalls
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles, write channel %s",
                     cycle_limit, i_dut.i_regs.wr_state.name());
            $display("*** FAILED ***");
            $finish;
        end
    end

    // 16-bit Galois LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    // One LFSR step for every bit gathered
    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | lfsr_state[0];
        end
        return value;
    endfunction

    function automatic void report_value(input string what, input logic [31:0] got,
                                         input logic [31:0] expected);
        error_count++;
        $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
    endfunction

    // One result line per test
    function automatic void finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: %0d mismatches", name, error_count - errors_before);
        end
    endfunction

    `include "tb_encoder_tasks.svh"

    initial begin
        clock        = 1'b0;
        rst_n        = 1'b0;
        a            = 1'b0;
        b            = 1'b0;
        z            = 1'b0;
        sample_angle = 1'b0;
        sample_speed = 1'b0;
        angle_tready = 1'b0;
        speed_tready = 1'b0;
        axil_req     = '0;
        quad_pos     = 0;
        lfsr_state   = 16'd2833;
        cycle_count  = 0;
        error_count  = 0;
        pass_count   = 0;
        fail_count   = 0;
        repeat (8) @(negedge clock);
        rst_n = 1'b1;
        // Speed runs before any other Z activity so its zero period is observable
        check_register_access();
        measure_speed();
        count_forward();
        wrap_reverse();
        track_index();
        hold_under_backpressure();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* hdl/encoder_interface.sv */
/*
 * Quadrature encoder front end top level
 * Ties the AXI4-Lite register bank to the angle decoder and the index speed meter
 */
`timescale 1ns/1ps

module encoder_interface #(
    parameter int COUNTER_WIDTH = 24
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    a,
    input  logic                    b,
    input  logic                    z,
    input  logic                    sample_angle,
    input  logic                    sample_speed,
    input  encoder_pkg::axil_req_t  axil_req,
    output encoder_pkg::axil_rsp_t  axil_rsp,
    output encoder_pkg::axis_beat_t angle_beat,
    output logic                    angle_tvalid,
    input  logic                    angle_tready,
    output encoder_pkg::axis_beat_t speed_beat,
    output logic                    speed_tvalid,
    input  logic                    speed_tready
);

    // Configuration fans out to both measurement blocks
    encoder_pkg::encoder_cfg_t cfg;

    // Last sampled values, read back through registers 3 and 4
    logic [31:0] angle_value;
    logic [31:0] speed_value;

    // Z is synchronized once in the decoder and shared from there
    logic        index_pulse;

    axil_register_bank i_regs (
        .clock       (clock),
        .rst_n       (rst_n),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .cfg         (cfg),
        .angle_value (angle_value),
        .speed_value (speed_value)
    );

    quadrature_decoder i_angle (
        .clock       (clock),
        .rst_n       (rst_n),
        .a           (a),
        .b           (b),
        .z           (z),
        .sample      (sample_angle),
        .cfg         (cfg),
        .index_pulse (index_pulse),
        .beat        (angle_beat),
        .tvalid      (angle_tvalid),
        .tready      (angle_tready),
        .angle_value (angle_value)
    );

    index_speed_meter #(
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) i_speed (
        .clock       (clock),
        .rst_n       (rst_n),
        .index_pulse (index_pulse),
        .sample      (sample_speed),
        .cfg         (cfg),
        .beat        (speed_beat),
        .tvalid      (speed_tvalid),
        .tready      (speed_tready),
        .speed_value (speed_value)
    );

endmodule

/* hdl/index_speed_meter.sv */
/*
 * Index period meter
 * Counts clock cycles between index pulses and streams the period
 * latched on each sample strobe
 */
`timescale 1ns/1ps

module index_speed_meter #(
    parameter int COUNTER_WIDTH = 24
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      index_pulse,
    input  logic                      sample,
    input  encoder_pkg::encoder_cfg_t cfg,
    output encoder_pkg::axis_beat_t   beat,
    output logic                      tvalid,
    input  logic                      tready,
    output logic [31:0]               speed_value
);

    logic [COUNTER_WIDTH-1:0] cycle_count;
    logic [COUNTER_WIDTH-1:0] period;
    logic                     seen_index;

    encoder_pkg::axis_beat_t  beat_q;
    logic                     tvalid_q;

    // Counter restarts at 1 so the captured value equals the pulse spacing
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cycle_count <= '0;
            period      <= '0;
            seen_index  <= 1'b0;
        end else if (index_pulse) begin
            cycle_count <= COUNTER_WIDTH'(1);
            seen_index  <= 1'b1;
            // The first pulse only starts the measurement
            if (seen_index) begin
                period <= cycle_count;
            end
        end else if (cycle_count != '1) begin
            // Saturate rather than wrap when the shaft stops
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // Same sample and hold-until-accepted rule as the angle stream
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            beat_q   <= '0;
            tvalid_q <= 1'b0;
        end else if (sample && !tvalid_q) begin
            beat_q.tdata <= 32'(period);
            beat_q.tdest <= cfg.speed_dest;
            tvalid_q     <= 1'b1;
        end else if (tvalid_q && tready) begin
            tvalid_q <= 1'b0;
        end
    end

    assign beat        = beat_q;
    assign tvalid      = tvalid_q;
    assign speed_value = beat_q.tdata;

endmodule

/* hdl/quadrature_decoder.sv */
/*
 * Quadrature decoder with index tracking
 * Counts every A/B Gray-code transition, wraps at counts per revolution
 * and streams the angle latched on each sample strobe
 */
`timescale 1ns/1ps

module quadrature_decoder (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      a,
    input  logic                      b,
    input  logic                      z,
    input  logic                      sample,
    input  encoder_pkg::encoder_cfg_t cfg,
    output logic                      index_pulse,
    output encoder_pkg::axis_beat_t   beat,
    output logic                      tvalid,
    input  logic                      tready,
    output logic [31:0]               angle_value
);

    // Encoder lines packed as {z, b, a} through both synchronizer stages
    logic [2:0]  sync_meta;
    logic [2:0]  sync_q;
    logic [2:0]  prev_q;

    logic [1:0]  ab_prev;
    logic [1:0]  ab_cur;
    logic        z_rise;
    logic        step_up;
    logic        step_down;

    logic [23:0] count;
    logic [23:0] max_m1;
    encoder_pkg::axis_beat_t beat_q;
    logic        tvalid_q;

    assign ab_prev = {prev_q[0], prev_q[1]};
    assign ab_cur  = {sync_q[0], sync_q[1]};
    assign z_rise  = sync_q[2] && !prev_q[2];
    assign max_m1  = cfg.max_count - 24'd1;

    // Forward follows 00 10 11 01 with A leading, reverse runs the other way
    // Transitions that flip both lines at once carry no direction and are dropped
    always_comb begin
        step_up   = 1'b0;
        step_down = 1'b0;
        case ({ab_prev, ab_cur})
            4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: step_up = 1'b1;
            4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: step_down = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sync_meta   <= 3'd0;
            sync_q      <= 3'd0;
            prev_q      <= 3'd0;
            index_pulse <= 1'b0;
            count       <= 24'd0;
        end else begin
            sync_meta   <= {z, b, a};
            sync_q      <= sync_meta;
            prev_q      <= sync_q;
            index_pulse <= z_rise;
            if (cfg.max_count == 24'd0) begin
                count <= 24'd0;
            end else if (cfg.index_tracking && z_rise) begin
                // Index wins over a step in the same cycle
                count <= 24'd0;
            end else if (step_up) begin
                count <= (count >= max_m1) ? 24'd0 : count + 24'd1;
            end else if (step_down) begin
                count <= (count == 24'd0 || count > max_m1) ? max_m1 : count - 24'd1;
            end
        end
    end

    // Sample register doubles as the pending stream beat
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            beat_q   <= '0;
            tvalid_q <= 1'b0;
        end else if (sample && !tvalid_q) begin
            beat_q.tdata <= {8'd0, count};
            beat_q.tdest <= cfg.angle_dest;
            tvalid_q     <= 1'b1;
        end else if (tvalid_q && tready) begin
            tvalid_q <= 1'b0;
        end
    end

    assign beat        = beat_q;
    assign tvalid      = tvalid_q;
    assign angle_value = beat_q.tdata;

endmodule

/* hdl/axil_register_bank.sv */
/*
 * AXI4-Lite register bank for the encoder front end
 * Stores the stream destinations, counts per revolution and control word,
 * and returns the latest sampled angle and speed on reads
 */
`timescale 1ns/1ps

module axil_register_bank (
    input  logic                      clock,
    input  logic                      rst_n,
    input  encoder_pkg::axil_req_t    axil_req,
    output encoder_pkg::axil_rsp_t    axil_rsp,
    output encoder_pkg::encoder_cfg_t cfg,
    input  logic [31:0]               angle_value,
    input  logic [31:0]               speed_value
);

    encoder_pkg::axil_state_e wr_state;
    encoder_pkg::axil_state_e rd_state;

    // Address or data that arrived before its partner
    logic        aw_held;
    logic        w_held;
    logic [7:0]  wr_addr;
    logic [31:0] wr_data;

    logic        aw_fire;
    logic        w_fire;
    logic        wr_go;
    logic [7:0]  go_addr;
    logic [31:0] go_data;

    logic [1:0]  bresp_q;
    logic [31:0] rdata_q;
    logic [1:0]  rresp_q;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;

    // Writable registers, kept at full width so reads give back what was written
    logic [31:0] angle_dest_q;
    logic [31:0] speed_dest_q;
    logic [31:0] max_count_q;
    logic [31:0] control_q;

    // Each side is ready until it holds its half of the write
    assign axil_rsp.awready = (wr_state == encoder_pkg::idle) ||
                              (wr_state == encoder_pkg::wait_data && !aw_held);
    assign axil_rsp.wready  = (wr_state == encoder_pkg::idle) ||
                              (wr_state == encoder_pkg::wait_data && !w_held);
    assign axil_rsp.bvalid  = (wr_state == encoder_pkg::respond);
    assign axil_rsp.bresp   = bresp_q;
    assign axil_rsp.arready = (rd_state == encoder_pkg::idle);
    assign axil_rsp.rvalid  = (rd_state == encoder_pkg::respond);
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = rresp_q;

    assign aw_fire = axil_req.awvalid && axil_rsp.awready;
    assign w_fire  = axil_req.wvalid && axil_rsp.wready;

    // The write commits on the edge where both halves are available
    assign wr_go   = (aw_fire || aw_held) && (w_fire || w_held);
    assign go_addr = aw_held ? wr_addr : axil_req.awaddr;
    assign go_data = w_held ? wr_data : axil_req.wdata;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_state     <= encoder_pkg::idle;
            aw_held      <= 1'b0;
            w_held       <= 1'b0;
            wr_addr      <= 8'd0;
            wr_data      <= 32'd0;
            bresp_q      <= encoder_pkg::resp_okay;
            angle_dest_q <= 32'd0;
            speed_dest_q <= 32'd0;
            max_count_q  <= 32'd0;
            control_q    <= 32'd0;
        end else begin
            case (wr_state)
                encoder_pkg::idle, encoder_pkg::wait_data: begin
                    if (wr_go) begin
                        case (go_addr[7:2])
                            encoder_pkg::reg_angle_dest: angle_dest_q <= go_data;
                            encoder_pkg::reg_speed_dest: speed_dest_q <= go_data;
                            encoder_pkg::reg_max_count:  max_count_q  <= go_data;
                            encoder_pkg::reg_control:    control_q    <= go_data;
                            default: ;
                        endcase
                        // Measurement registers take the write silently, anything past them errors
                        bresp_q  <= (go_addr[7:2] > encoder_pkg::reg_control) ?
                                    encoder_pkg::resp_slverr : encoder_pkg::resp_okay;
                        aw_held  <= 1'b0;
                        w_held   <= 1'b0;
                        wr_state <= encoder_pkg::respond;
                    end else begin
                        if (aw_fire) begin
                            aw_held <= 1'b1;
                            wr_addr <= axil_req.awaddr;
                        end
                        if (w_fire) begin
                            w_held  <= 1'b1;
                            wr_data <= axil_req.wdata;
                        end
                        if (aw_fire || w_fire) begin
                            wr_state <= encoder_pkg::wait_data;
                        end
                    end
                end
                default: begin
                    // Response stays up until the master takes it
                    if (axil_req.bready) begin
                        wr_state <= encoder_pkg::idle;
                    end
                end
            endcase
        end
    end

    // Read data selection straight from the incoming address
    always_comb begin
        rd_resp = encoder_pkg::resp_okay;
        case (axil_req.araddr[7:2])
            encoder_pkg::reg_angle_dest: rd_data = angle_dest_q;
            encoder_pkg::reg_speed_dest: rd_data = speed_dest_q;
            encoder_pkg::reg_max_count:  rd_data = max_count_q;
            encoder_pkg::reg_angle:      rd_data = angle_value;
            encoder_pkg::reg_speed:      rd_data = speed_value;
            encoder_pkg::reg_control:    rd_data = control_q;
            default: begin
                rd_data = 32'd0;
                rd_resp = encoder_pkg::resp_slverr;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_state <= encoder_pkg::idle;
            rdata_q  <= 32'd0;
            rresp_q  <= encoder_pkg::resp_okay;
        end else if (rd_state == encoder_pkg::idle) begin
            if (axil_req.arvalid) begin
                rdata_q  <= rd_data;
                rresp_q  <= rd_resp;
                rd_state <= encoder_pkg::respond;
            end
        end else if (axil_req.rready) begin
            rd_state <= encoder_pkg::idle;
        end
    end

    // Configuration view of the stored registers
    always_comb begin
        cfg.angle_dest     = angle_dest_q[7:0];
        cfg.speed_dest     = speed_dest_q[7:0];
        cfg.max_count      = max_count_q[23:0];
        cfg.index_tracking = control_q[0];
        cfg.control        = control_q;
    end

endmodule

/* hdl/encoder_pkg.sv */
/*
 * Encoder front end shared definitions
 * Holds the register map, the AXI4-Lite and AXI-Stream payload structs,
 * the bus channel states and the configuration handed to the measurement blocks
 */
package encoder_pkg;

    // Word registers, register n sits at byte address 4n
    typedef enum logic [5:0] {
        reg_angle_dest = 6'd0,
        reg_speed_dest = 6'd1,
        reg_max_count  = 6'd2,
        reg_angle      = 6'd3,
        reg_speed      = 6'd4,
        reg_control    = 6'd5
    } reg_idx_e;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Everything the AXI4-Lite master drives toward the slave
    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // Everything the slave returns to the master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    // Stream payload, tvalid and tready travel beside it
    typedef struct packed {
        logic [31:0] tdata;
        logic [7:0]  tdest;
    } axis_beat_t;

    // Channel state shared by the write and read sides of the slave
    typedef enum logic [1:0] {
        idle,
        wait_data,
        respond
    } axil_state_e;

    // Configuration seen by the measurement blocks
    typedef struct packed {
        logic [7:0]  angle_dest;
        logic [7:0]  speed_dest;
        logic [23:0] max_count;
        logic        index_tracking;
        logic [31:0] control;
    } encoder_cfg_t;

endpackage
